/* verif/seq_stimulus.txt */
// columns, all hex: instruction byte, alu_flags, step count, expected ccr, goto taken
// ccr and flags bits: carry 2, sign 1, zero 0
01 5 08 0 0 // mov8 a <- b
1e 0 08 0 0 // mov8 d <- x
12 7 08 0 0 // mov8 c <- c clears c
3d 2 08 0 0 // mov8 y <- m2
55 6 08 0 0 // setab a
63 1 08 0 0 // setab b
85 4 08 4 0 // alu to a, func 5, carry set
c0 0 18 4 1 // goto unconditional
c8 3 18 4 1 // goto on carry
c4 1 18 4 0 // goto on zero, not taken
e2 0 18 4 1 // goto not-zero with link
8a 3 08 3 0 // alu to d, func 2, sign and zero
f8 4 18 3 1 // goto sign or carry with link
ca 0 18 3 0 // goto carry or not-zero, not taken
92 5 0c 3 0 // load c
9d 2 0c 3 0 // store b
a4 1 0a 3 0 // mov16 xy from j
a8 6 0a 3 0 // mov16 pc from m
b5 7 0e 3 0 // inc16
80 0 08 0 0 // alu to a, func 0, flags clear
c6 7 18 0 1 // goto zero or not-zero
dc 0 18 0 0 // goto sign, carry or zero, not taken
b8 7 01 0 0 // halt

/* filelist.f */
common/seq_pkg.sv
decoder/inst_decoder.sv
decoder/cond_code_reg.sv
src/step_sequencer.sv
src/control_matrix.sv
src/sequencer_unit.sv
verif/tb_sequencer_unit.sv

/* run_sim.sh */
#!/bin/sh
# builds the sequencer unit testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f filelist.f --top-module tb_sequencer_unit -Mdir obj_dir

./obj_dir/Vtb_sequencer_unit | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* verif/tb_sequencer_unit.sv */
// sequencer unit testbench: runs the instructions from the stimulus file against the strobe table
`default_nettype none

module tb_sequencer_unit import seq_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_LINES = 64;
  localparam int COLS      = 5; // byte, flags, steps, ccr, goto

  logic              clk;
  logic              rst_n;
  logic              inst_valid;
  logic              inst_ready;
  logic [7:0]        inst_byte;
  logic [2:0]        alu_flags;
  logic [7:0]        ld_reg;
  logic [7:0]        sel_reg;
  logic [MISC_W-1:0] misc_ctrl;
  logic [2:0]        alu_func;
  logic [2:0]        ccr;
  logic              done;
  logic              halted;

  logic [15:0] stim_mem [0:MAX_LINES*COLS-1];
  int          errors;
  int          checks;
  int          cycle_count;
  int          cycle_limit;

  sequencer_unit dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .inst_byte  (inst_byte),
    .alu_flags  (alu_flags),
    .ld_reg     (ld_reg),
    .sel_reg    (sel_reg),
    .misc_ctrl  (misc_ctrl),
    .alu_func   (alu_func),
    .ccr        (ccr),
    .done       (done),
    .halted     (halted)
  );

  always #2 clk = ~clk;

  // cycle limit derived from the file contents
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    checks++;
    if (act_val !== exp_val) begin
      errors++;
      $display("Error %s expected %0h actual %0h", name, exp_val, act_val);
    end
  endtask

  function automatic bit in_window(input int s, input int lo, input int hi);
    return (s >= lo) && (s <= hi);
  endfunction

  // reference table packed as {ld_reg, sel_reg, misc_ctrl, alu_func}
  function automatic logic [31:0] expected_strobes(input logic [7:0] b, input int s,
                                                   input logic taken);
    logic [7:0]        ld;
    logic [7:0]        sl;
    logic [MISC_W-1:0] mc;
    logic [2:0]        af;
    ld = '0;
    sl = '0;
    mc = '0;
    af = '0;
    if (b[7:6] == 2'b00) begin // mov8
      if (in_window(s, 2, 6) && b[5:3] != b[2:0]) sl[b[2:0]] = 1'b1;
      if (in_window(s, 3, 5)) ld[b[5:3]] = 1'b1;
    end else if (b[7:6] == 2'b01) begin // setab
      mc[M_SEL_IMM] = in_window(s, 2, 6);
      if (in_window(s, 3, 5)) ld[b[5] ? REG_B : REG_A] = 1'b1;
    end else if (b[7:6] == 2'b11) begin // goto
      mc[M_SEL_PC]   = in_window(s, 2, 8) || in_window(s, 10, 16);
      mc[M_MEM_READ] = mc[M_SEL_PC];
      mc[M_SEL_M]    = in_window(s, 18, 22);
      mc[M_LD_PC]    = in_window(s, 19, 21) && taken;
      mc[M_LD_XY]    = in_window(s, 19, 21) && b[5];
      if (in_window(s, 4, 6)) ld[REG_M1] = 1'b1;
      if (in_window(s, 12, 14)) ld[REG_M2] = 1'b1;
    end else begin
      case (b[5:4])
        2'b00: begin // alu
          mc[M_SEL_ALU] = in_window(s, 2, 6);
          mc[M_LD_CCR]  = in_window(s, 3, 5);
          if (in_window(s, 3, 5)) ld[b[3] ? REG_D : REG_A] = 1'b1;
          if (in_window(s, 1, 8)) af = b[2:0];
        end
        2'b01: begin // load or store
          mc[M_SEL_M] = in_window(s, 2, 10);
          if (b[3]) begin
            mc[M_MEM_WRITE] = in_window(s, 5, 7);
            if (in_window(s, 4, 8)) sl[{1'b0, b[1:0]}] = 1'b1;
          end else begin
            mc[M_MEM_READ] = in_window(s, 4, 8);
            if (in_window(s, 5, 7)) ld[{1'b0, b[1:0]}] = 1'b1;
          end
        end
        2'b10: begin // mov16
          mc[M_SEL_M] = in_window(s, 2, 8) && !b[2];
          mc[M_SEL_J] = in_window(s, 2, 8) && b[2];
          mc[M_LD_XY] = in_window(s, 3, 6) && !b[3];
          mc[M_LD_PC] = in_window(s, 3, 6) && b[3];
        end
        default: begin // inc16 only as halt has no strobes
          if (!b[3]) begin
            mc[M_SEL_XY]  = in_window(s, 2, 6);
            mc[M_LD_INC]  = in_window(s, 3, 5);
            mc[M_SEL_INC] = in_window(s, 8, 12);
            mc[M_LD_XY]   = in_window(s, 9, 11);
          end
        end
      endcase
    end
    return {ld, sl, mc, af};
  endfunction

  task automatic run_instruction(input int idx, input logic [7:0] b, input logic [2:0] flags,
                                 input int n, input logic [2:0] exp_ccr, input logic taken);
    int    gap;
    string tag;
    tag = $sformatf("line %0d", idx);
    @(posedge clk);
    #1;
    inst_valid = 1'b0;
    alu_flags  = flags; // held for the whole instruction
    gap = int'($urandom % 4);
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    inst_byte  = b;
    inst_valid = 1'b1;
    @(negedge clk);
    check_value({tag, " ready before accept"}, 32'd1, 32'(inst_ready));
    @(posedge clk); // accept edge
    #1;
    inst_valid = 1'b0;
    for (int s = 1; s <= n; s++) begin
      @(negedge clk);
      check_value($sformatf("%s step %0d strobes", tag, s), expected_strobes(b, s, taken),
                  {ld_reg, sel_reg, misc_ctrl, alu_func});
      check_value($sformatf("%s step %0d done", tag, s), 32'(s == n), 32'(done));
      check_value($sformatf("%s step %0d ready", tag, s), 32'd0, 32'(inst_ready));
      if (s < n) begin
        @(posedge clk);
        #1;
      end
    end
    @(posedge clk);
    #1;
    if (b[7:3] == 5'b10111) begin
      inst_valid = 1'b1; // must be ignored once halted
      inst_byte  = 8'h01;
      repeat (20) begin
        @(negedge clk);
        check_value({tag, " halted"}, 32'd1, 32'(halted));
        check_value({tag, " ready while halted"}, 32'd0, 32'(inst_ready));
        check_value({tag, " done while halted"}, 32'd0, 32'(done));
        check_value({tag, " strobes while halted"}, 32'd0,
                    {ld_reg, sel_reg, misc_ctrl, alu_func});
        @(posedge clk);
        #1;
      end
    end else begin
      @(negedge clk);
      check_value({tag, " ready after end"}, 32'd1, 32'(inst_ready));
      check_value({tag, " done after end"}, 32'd0, 32'(done));
      check_value({tag, " strobes after end"}, 32'd0, {ld_reg, sel_reg, misc_ctrl, alu_func});
    end
    check_value({tag, " ccr"}, 32'(exp_ccr), 32'(ccr));
  endtask

  initial begin
    int n_lines;
    int base;
    clk         = 1'b0;
    rst_n       = 1'b0;
    inst_valid  = 1'b0;
    inst_byte   = '0;
    alu_flags   = '0;
    errors      = 0;
    checks      = 0;
    cycle_count = 0;
    void'($urandom(99199));
    for (int i = 0; i < MAX_LINES * COLS; i++) begin
      stim_mem[i] = 16'h8000 | 16'(i); // bit 15 marks entries the file leaves alone
    end
    $readmemh("verif/seq_stimulus.txt", stim_mem);
    n_lines = 0;
    while (n_lines < MAX_LINES && !stim_mem[n_lines * COLS][15]) n_lines++;
    cycle_limit = 200;
    for (int i = 0; i < n_lines; i++) cycle_limit += int'(stim_mem[i * COLS + 2]) + 5;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("reset ready", 32'd1, 32'(inst_ready));
    check_value("reset strobes", 32'd0, {ld_reg, sel_reg, misc_ctrl, alu_func});
    check_value("reset done", 32'd0, 32'(done));
    check_value("reset halted", 32'd0, 32'(halted));
    check_value("reset ccr", 32'd0, 32'(ccr));
    if (n_lines == 0) begin
      $display("no instructions could be read from verif/seq_stimulus.txt");
      errors++;
    end
    for (int i = 0; i < n_lines; i++) begin
      base = i * COLS;
      run_instruction(i + 1, stim_mem[base][7:0], stim_mem[base + 1][2:0],
                      int'(stim_mem[base + 2]), stim_mem[base + 3][2:0], stim_mem[base + 4][0]);
    end
    $display("instructions: %0d checks: %0d errors: %0d", n_lines, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/sequencer_unit.sv */
// sequencer unit top: handshake, decoder, condition codes and strobe matrix
`default_nettype none

module sequencer_unit import seq_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              inst_valid,
  output logic              inst_ready,
  input  logic [7:0]        inst_byte,
  input  logic [2:0]        alu_flags,
  output logic [7:0]        ld_reg,
  output logic [7:0]        sel_reg,
  output logic [MISC_W-1:0] misc_ctrl,
  output logic [2:0]        alu_func,
  output logic [2:0]        ccr,
  output logic              done,
  output logic              halted
);

  logic        accept;
  logic [4:0]  len_code;
  logic        is_halt;
  logic [4:0]  step;
  inst_class_e inst_class;
  logic [2:0]  dst_idx;
  logic [2:0]  src_idx;
  logic [1:0]  reg_sel;
  logic        alt_bit;
  logic [2:0]  func;
  logic [3:0]  goto_cond;
  logic        link;
  logic        goto_taken;

  step_sequencer step_sequencer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .accept     (accept),
    .len_code   (len_code),
    .is_halt    (is_halt),
    .step       (step),
    .done       (done),
    .halted     (halted)
  );

  inst_decoder inst_decoder_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .accept     (accept),
    .inst_byte  (inst_byte),
    .inst_class (inst_class),
    .len_code   (len_code),
    .is_halt    (is_halt),
    .dst_idx    (dst_idx),
    .src_idx    (src_idx),
    .reg_sel    (reg_sel),
    .alt_bit    (alt_bit),
    .func       (func),
    .goto_cond  (goto_cond),
    .link       (link)
  );

  cond_code_reg cond_code_reg_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .ld_ccr     (misc_ctrl[M_LD_CCR]), // fed back from the matrix
    .alu_flags  (alu_flags),
    .goto_cond  (goto_cond),
    .ccr        (ccr),
    .goto_taken (goto_taken)
  );

  control_matrix control_matrix_i (
    .step       (step),
    .inst_class (inst_class),
    .dst_idx    (dst_idx),
    .src_idx    (src_idx),
    .reg_sel    (reg_sel),
    .alt_bit    (alt_bit),
    .func       (func),
    .link       (link),
    .goto_taken (goto_taken),
    .ld_reg     (ld_reg),
    .sel_reg    (sel_reg),
    .misc_ctrl  (misc_ctrl),
    .alu_func   (alu_func)
  );

endmodule

`default_nettype wire

/* src/control_matrix.sv */
// control matrix: decodes step windows per class into register and misc strobes
`default_nettype none

module control_matrix import seq_pkg::*; (
  input  logic [4:0]        step,
  input  inst_class_e       inst_class,
  input  logic [2:0]        dst_idx,
  input  logic [2:0]        src_idx,
  input  logic [1:0]        reg_sel,
  input  logic              alt_bit,
  input  logic [2:0]        func,
  input  logic              link,
  input  logic              goto_taken,
  output logic [7:0]        ld_reg,
  output logic [7:0]        sel_reg,
  output logic [MISC_W-1:0] misc_ctrl,
  output logic [2:0]        alu_func
);

  // inclusive step window
  function automatic logic in_win(input logic [4:0] s,
                                  input logic [4:0] lo,
                                  input logic [4:0] hi);
    return (s >= lo) && (s <= hi);
  endfunction

  function automatic logic [7:0] onehot(input logic [2:0] idx);
    return 8'b1 << idx;
  endfunction

  always_comb begin
    ld_reg    = '0;
    sel_reg   = '0;
    misc_ctrl = '0;
    alu_func  = '0;
    case (inst_class)
      CLS_MOV8: begin
        if (in_win(step, 5'd2, 5'd6) && (dst_idx != src_idx))
          sel_reg = onehot(src_idx); // same reg means clear
        if (in_win(step, 5'd3, 5'd5))
          ld_reg = onehot(dst_idx);
      end
      CLS_SETAB: begin
        misc_ctrl[M_SEL_IMM] = in_win(step, 5'd2, 5'd6);
        if (in_win(step, 5'd3, 5'd5))
          ld_reg = onehot(dst_idx);
      end
      CLS_ALU: begin
        misc_ctrl[M_SEL_ALU] = in_win(step, 5'd2, 5'd6);
        misc_ctrl[M_LD_CCR]  = in_win(step, 5'd3, 5'd5);
        if (in_win(step, 5'd3, 5'd5))
          ld_reg = onehot(dst_idx);
        if (in_win(step, 5'd1, 5'd8))
          alu_func = func;
      end
      CLS_LOAD: begin
        misc_ctrl[M_SEL_M]    = in_win(step, 5'd2, 5'd10);
        misc_ctrl[M_MEM_READ] = in_win(step, 5'd4, 5'd8);
        if (in_win(step, 5'd5, 5'd7))
          ld_reg = onehot({1'b0, reg_sel});
      end
      CLS_STORE: begin
        misc_ctrl[M_SEL_M]     = in_win(step, 5'd2, 5'd10);
        misc_ctrl[M_MEM_WRITE] = in_win(step, 5'd5, 5'd7);
        if (in_win(step, 5'd4, 5'd8))
          sel_reg = onehot({1'b0, reg_sel});
      end
      CLS_MOV16: begin
        misc_ctrl[M_SEL_M] = in_win(step, 5'd2, 5'd8) & ~alt_bit;
        misc_ctrl[M_SEL_J] = in_win(step, 5'd2, 5'd8) & alt_bit;
        misc_ctrl[M_LD_XY] = in_win(step, 5'd3, 5'd6) & ~dst_idx[0];
        misc_ctrl[M_LD_PC] = in_win(step, 5'd3, 5'd6) & dst_idx[0];
      end
      CLS_INC16: begin
        // two passes through the incrementer
        misc_ctrl[M_SEL_XY]  = in_win(step, 5'd2, 5'd6);
        misc_ctrl[M_LD_INC]  = in_win(step, 5'd3, 5'd5);
        misc_ctrl[M_SEL_INC] = in_win(step, 5'd8, 5'd12);
        misc_ctrl[M_LD_XY]   = in_win(step, 5'd9, 5'd11);
      end
      CLS_GOTO: begin
        // fetch both address bytes, then transfer through m
        misc_ctrl[M_SEL_PC]   = in_win(step, 5'd2, 5'd8) | in_win(step, 5'd10, 5'd16);
        misc_ctrl[M_MEM_READ] = in_win(step, 5'd2, 5'd8) | in_win(step, 5'd10, 5'd16);
        misc_ctrl[M_SEL_M]    = in_win(step, 5'd18, 5'd22);
        misc_ctrl[M_LD_PC]    = in_win(step, 5'd19, 5'd21) & goto_taken;
        misc_ctrl[M_LD_XY]    = in_win(step, 5'd19, 5'd21) & link; // return address
        if (in_win(step, 5'd4, 5'd6))
          ld_reg = onehot(REG_M1);
        else if (in_win(step, 5'd12, 5'd14))
          ld_reg = onehot(REG_M2);
      end
      default: ; // idle and halt drive nothing
    endcase
  end

endmodule

`default_nettype wire

/* src/step_sequencer.sv */
// step sequencer: instruction handshake, step counting, end-of-instruction and halt lock
`default_nettype none

module step_sequencer (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       inst_valid,
  output logic       inst_ready,
  output logic       accept,
  input  logic [4:0] len_code,
  input  logic       is_halt,
  output logic [4:0] step,
  output logic       done,
  output logic       halted
);

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_RUN  = 2'd1,
    ST_HALT = 2'd2
  } state_e;

  state_e     state_q;
  logic [4:0] step_q;
  logic       last_step;

  assign inst_ready = (state_q == ST_IDLE);
  assign accept     = inst_valid & inst_ready;
  assign last_step  = (state_q == ST_RUN) && (step_q == len_code);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q <= ST_RUN;
            step_q  <= 5'd1; // first step follows the accept edge
          end
        end
        ST_RUN: begin
          if (last_step) begin
            state_q <= is_halt ? ST_HALT : ST_IDLE;
            step_q  <= '0;
          end else begin
            step_q <= step_q + 5'd1;
          end
        end
        ST_HALT: begin
          step_q <= '0; // stays here until reset
        end
        default: begin
          state_q <= ST_IDLE;
          step_q  <= '0;
        end
      endcase
    end
  end

  assign step   = step_q;
  assign done   = last_step;
  assign halted = (state_q == ST_HALT);

endmodule

`default_nettype wire

/* decoder/cond_code_reg.sv */
// condition code register: holds carry, sign and zero and evaluates the GOTO condition
`default_nettype none

module cond_code_reg import seq_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       ld_ccr,
  input  logic [2:0] alu_flags,
  input  logic [3:0] goto_cond,
  output logic [2:0] ccr,
  output logic       goto_taken
);

  logic [2:0] ccr_q;
  logic       sign_hit;
  logic       carry_hit;
  logic       zero_hit;
  logic       nzero_hit;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ccr_q <= '0;
    end else if (ld_ccr) begin
      ccr_q <= alu_flags; // same bit order as ccr
    end
  end

  assign ccr = ccr_q;

  // cond field is s c z n from msb down
  assign sign_hit  = goto_cond[3] & ccr_q[CCR_SIGN];
  assign carry_hit = goto_cond[2] & ccr_q[CCR_CARRY];
  assign zero_hit  = goto_cond[1] & ccr_q[CCR_ZERO];
  assign nzero_hit = goto_cond[0] & ~ccr_q[CCR_ZERO];

  // empty condition field means always jump
  assign goto_taken = (goto_cond == 4'd0) | sign_hit | carry_hit | zero_hit | nzero_hit;

endmodule

`default_nettype wire

/* decoder/inst_decoder.sv */
// instruction decoder: latches the byte, classifies it and extracts fields through the union
`default_nettype none

module inst_decoder import seq_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              accept,
  input  logic [7:0]        inst_byte,
  output inst_class_e       inst_class,
  output logic [4:0]        len_code,
  output logic              is_halt,
  output logic [2:0]        dst_idx,
  output logic [2:0]        src_idx,
  output logic [1:0]        reg_sel,
  output logic              alt_bit,
  output logic [2:0]        func,
  output logic [3:0]        goto_cond,
  output logic              link
);

  inst_u       inst_in;
  inst_u       inst_q;
  inst_class_e class_in;
  inst_class_e class_q;

  assign inst_in = inst_byte;

  // opcode tree with two bits first then four
  always_comb begin
    case (inst_in.mov8.op)
      2'b00: class_in = CLS_MOV8;
      2'b01: class_in = CLS_SETAB;
      2'b11: class_in = CLS_GOTO;
      default: begin
        case (inst_in.alu.op)
          4'b1000: class_in = CLS_ALU;
          4'b1001: class_in = inst_in.mem.store ? CLS_STORE : CLS_LOAD;
          4'b1010: class_in = CLS_MOV16;
          default: class_in = inst_in.mem.store ? CLS_HALT : CLS_INC16; // 1011x
        endcase
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      class_q <= CLS_IDLE;
    end else if (accept) begin
      class_q <= class_in;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q <= inst_in; // held for the whole instruction
    end
  end

  assign inst_class = class_q;
  assign is_halt    = (class_q == CLS_HALT);

  always_comb begin
    case (class_q)
      CLS_MOV8:            len_code = STEPS_MOV8;
      CLS_SETAB:           len_code = STEPS_SETAB;
      CLS_ALU:             len_code = STEPS_ALU;
      CLS_LOAD, CLS_STORE: len_code = STEPS_MEM;
      CLS_MOV16:           len_code = STEPS_MOV16;
      CLS_INC16:           len_code = STEPS_INC16;
      CLS_GOTO:            len_code = STEPS_GOTO;
      CLS_HALT:            len_code = STEPS_HALT;
      default:             len_code = 5'd0;
    endcase
  end

  // field extraction with one view per class
  always_comb begin
    dst_idx   = '0;
    src_idx   = '0;
    reg_sel   = '0;
    alt_bit   = 1'b0;
    func      = '0;
    goto_cond = '0;
    link      = 1'b0;
    case (class_q)
      CLS_MOV8: begin
        dst_idx = inst_q.mov8.dst;
        src_idx = inst_q.mov8.src;
      end
      CLS_SETAB: dst_idx = inst_q.setab.reg_b ? REG_B : REG_A;
      CLS_ALU: begin
        dst_idx = inst_q.alu.dst_d ? REG_D : REG_A;
        func    = inst_q.alu.func;
      end
      CLS_LOAD, CLS_STORE: reg_sel = inst_q.mem.reg_idx;
      CLS_MOV16: begin
        dst_idx = {2'b00, inst_q.mem.store}; // d is 1 for pc
        alt_bit = inst_q.mem.spare;          // s is 1 for j
      end
      CLS_GOTO: begin
        goto_cond = inst_q.goto.cond;
        link      = inst_q.goto.link;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* common/seq_pkg.sv */
// sequencer package: instruction layouts, classes, step counts and strobe bit positions
`default_nettype none

package seq_pkg;

  // 00dddsss
  typedef struct packed {
    logic [1:0] op;
    logic [2:0] dst;
    logic [2:0] src;
  } mov8_view_t;

  // 01rvvvvv
  typedef struct packed {
    logic [1:0] op;
    logic       reg_b;
    logic [4:0] imm;
  } setab_view_t;

  // 1000rfff
  typedef struct packed {
    logic [3:0] op;
    logic       dst_d;
    logic [2:0] func;
  } alu_view_t;

  // 1001sxrr, also carries ds of MOV16 in store/spare
  typedef struct packed {
    logic [3:0] op;
    logic       store;
    logic       spare;
    logic [1:0] reg_idx;
  } mem_view_t;

  // 11lscznx
  typedef struct packed {
    logic [1:0] op;
    logic       link;
    logic [3:0] cond; // sign, carry, zero, not-zero
    logic       spare;
  } goto_view_t;

  typedef union packed {
    mov8_view_t  mov8;
    setab_view_t setab;
    alu_view_t   alu;
    mem_view_t   mem;
    goto_view_t  goto;
  } inst_u;

  typedef enum logic [3:0] {
    CLS_IDLE  = 4'd0,
    CLS_MOV8  = 4'd1,
    CLS_SETAB = 4'd2,
    CLS_ALU   = 4'd3,
    CLS_LOAD  = 4'd4,
    CLS_STORE = 4'd5,
    CLS_MOV16 = 4'd6,
    CLS_INC16 = 4'd7,
    CLS_GOTO  = 4'd8,
    CLS_HALT  = 4'd9
  } inst_class_e;

  // timing steps per class
  localparam logic [4:0] STEPS_MOV8  = 5'd8;
  localparam logic [4:0] STEPS_SETAB = 5'd8;
  localparam logic [4:0] STEPS_ALU   = 5'd8;
  localparam logic [4:0] STEPS_MOV16 = 5'd10;
  localparam logic [4:0] STEPS_MEM   = 5'd12; // load and store
  localparam logic [4:0] STEPS_INC16 = 5'd14;
  localparam logic [4:0] STEPS_GOTO  = 5'd24;
  localparam logic [4:0] STEPS_HALT  = 5'd1;

  // positions in the 8-bit load/select vectors
  localparam logic [2:0] REG_A  = 3'd0;
  localparam logic [2:0] REG_B  = 3'd1;
  localparam logic [2:0] REG_C  = 3'd2;
  localparam logic [2:0] REG_D  = 3'd3;
  localparam logic [2:0] REG_M1 = 3'd4;
  localparam logic [2:0] REG_M2 = 3'd5;
  localparam logic [2:0] REG_X  = 3'd6;
  localparam logic [2:0] REG_Y  = 3'd7;

  // misc_ctrl bit positions
  localparam int M_MEM_READ  = 0;
  localparam int M_MEM_WRITE = 1;
  localparam int M_SEL_IMM   = 2;
  localparam int M_SEL_ALU   = 3;
  localparam int M_LD_CCR    = 4;
  localparam int M_SEL_M     = 5;
  localparam int M_SEL_J     = 6;
  localparam int M_SEL_XY    = 7;
  localparam int M_SEL_PC    = 8;
  localparam int M_SEL_INC   = 9;
  localparam int M_LD_XY     = 10;
  localparam int M_LD_PC     = 11;
  localparam int M_LD_INC    = 12;
  localparam int MISC_W      = 13;

  // ccr bit order
  localparam int CCR_CARRY = 2;
  localparam int CCR_SIGN  = 1;
  localparam int CCR_ZERO  = 0;

endpackage

`default_nettype wire
